// File: bench/qraccTileTb.sv
/*
 * Testbench for the compute-in-memory column tile
 * Clock, reset, weight and MAC stimulus, array mirror, checks and watchdog
 */

`timescale 1ns/1ns

module qraccTileTb import qraccPkg::*; ();

    localparam int clkPeriod = 8;
    localparam int numRwPairs = 8;
    localparam int numReads = 16;
    localparam int numMacs = 20;
    localparam int extremeRows = 40;
    // Two cycles per write, up to four per read or MAC
    localparam int testCycles = 16 + (numRows + extremeRows) * 2
        + (numRwPairs * 3 + numReads + numMacs + 16) * 4;

    logic     CLK = 1'b0;
    logic     rstN;
    logic     wrEn;
    rowAddr_t wrAddr;
    colWord_t wrData;
    logic     rdEn;
    rowAddr_t rdAddr;
    colWord_t rdData;
    logic     rdValid;
    logic     busy;
    logic     macStart;
    rowVec_t  actPos;
    rowVec_t  actNeg;
    adcVec_t  macResult;
    logic     macValid;

    colWord_t mirror [numRows];
    colWord_t rdExpQ [$];
    adcVec_t  macExpQ [$];
    colWord_t expWord;
    adcVec_t  expMac;
    logic     strobeSeen;
    int       seedInit;

    qraccTile uut (
        .CLK       (CLK),
        .rstN      (rstN),
        .wrEn      (wrEn),
        .wrAddr    (wrAddr),
        .wrData    (wrData),
        .rdEn      (rdEn),
        .rdAddr    (rdAddr),
        .rdData    (rdData),
        .rdValid   (rdValid),
        .busy      (busy),
        .macStart  (macStart),
        .actPos    (actPos),
        .actNeg    (actNeg),
        .macResult (macResult),
        .macValid  (macValid)
    );

    always #(clkPeriod / 2) CLK = ~CLK;

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    initial begin
        #((testCycles + 100) * clkPeriod);
        abortRun("Watchdog expired before the test finished");
    end

    // Status outputs stay quiet until the first request
    assert property (@(posedge CLK) disable iff (!rstN)
        !strobeSeen |-> !(busy || rdValid || macValid))
    else abortRun("A status output went high before any request");

    assert property (@(posedge CLK) disable iff (!rstN)
        (wrEn || rdEn) |-> ##1 busy ##1 !busy)
    else abortRun("busy was not high for exactly one cycle after a request");

    assert property (@(posedge CLK) disable iff (!rstN)
        (rdEn && !wrEn) |-> ##2 rdValid)
    else abortRun("rdValid did not pulse two edges after rdEn");

    assert property (@(posedge CLK) disable iff (!rstN)
        rdValid |-> $past(rdEn && !wrEn, 2))
    else abortRun("rdValid pulsed without a read two edges earlier");

    assert property (@(posedge CLK) disable iff (!rstN)
        macStart |-> ##2 macValid)
    else abortRun("macValid did not pulse two edges after macStart");

    assert property (@(posedge CLK) disable iff (!rstN)
        macValid |-> $past(macStart, 2))
    else abortRun("macValid pulsed without a MAC two edges earlier");

    // Results are compared mid-cycle where they are stable
    always @(negedge CLK) begin
        if (rstN && rdValid) begin
            assert (rdExpQ.size() > 0) else abortRun("Read data arrived with no read pending");
            expWord = rdExpQ.pop_front();
            assert (rdData === expWord)
            else abortRun($sformatf("ERROR rdData: expected 0x%h, got 0x%h", expWord, rdData));
        end
        if (rstN && macValid) begin
            assert (macExpQ.size() > 0) else abortRun("MAC result arrived with no MAC pending");
            expMac = macExpQ.pop_front();
            assert (macResult === expMac)
            else abortRun($sformatf("ERROR macResult: expected 0x%h, got 0x%h", expMac,
                macResult));
        end
    end

    // A row adds one on the positive rail alone and subtracts one on the negative rail alone
    function automatic adcVec_t expectedMac(input rowVec_t pos, input rowVec_t neg);
        adcVec_t     res;
        int          sum;
        logic [31:0] sumBits;
        for (int j = 0; j < numCols; j++) begin
            sum = 0;
            for (int i = 0; i < numRows; i++) begin
                if (mirror[i][j] && pos[i] && !neg[i]) begin
                    sum++;
                end
                if (mirror[i][j] && neg[i] && !pos[i]) begin
                    sum--;
                end
            end
            sumBits = sum;
            res[j*numAdcBits +: numAdcBits] = sumBits[5:2];
        end
        return res;
    endfunction

    function automatic rowVec_t rowRange(input int lo, input int hi);
        rowVec_t v;
        v = '0;
        for (int i = lo; i <= hi; i++) begin
            v[i] = 1'b1;
        end
        return v;
    endfunction

    task automatic randomActivation(output rowVec_t pos, output rowVec_t neg, input bit both);
        int pick;
        for (int i = 0; i < numRows; i++) begin
            pick = $urandom_range(both ? 3 : 2, 0);
            pos[i] = (pick == 1) || (pick == 3);
            neg[i] = (pick == 2) || (pick == 3);
        end
    endtask

    task automatic waitIdle();
        int n;
        n = 0;
        while (busy) begin
            assert (n < 8) else abortRun("Weight port stayed busy too long");
            n++;
            @(posedge CLK);
            #1;
        end
    endtask

    task automatic waitResults();
        int n;
        n = 0;
        while (rdExpQ.size() > 0 || macExpQ.size() > 0) begin
            assert (n < 8) else abortRun("An expected result never arrived");
            n++;
            @(posedge CLK);
            #1;
        end
    endtask

    task automatic writeRow(input rowAddr_t addr, input colWord_t data);
        wrEn         = 1'b1;
        wrAddr       = addr;
        wrData       = data;
        strobeSeen   = 1'b1;
        mirror[addr] = data;
        @(posedge CLK);
        #1;
        wrEn = 1'b0;
        waitIdle();
    endtask

    task automatic readRow(input rowAddr_t addr);
        rdEn       = 1'b1;
        rdAddr     = addr;
        strobeSeen = 1'b1;
        rdExpQ.push_back(mirror[addr]);
        @(posedge CLK);
        #1;
        rdEn = 1'b0;
        waitIdle();
        waitResults();
    endtask

    // Leaves macStart high so strobes can run back to back
    task automatic startMac(input rowVec_t pos, input rowVec_t neg);
        macStart   = 1'b1;
        actPos     = pos;
        actNeg     = neg;
        strobeSeen = 1'b1;
        macExpQ.push_back(expectedMac(pos, neg));
        @(posedge CLK);
        #1;
    endtask

    task automatic finishMacs();
        macStart = 1'b0;
        waitResults();
    endtask

    initial begin
        rowVec_t  pos;
        rowVec_t  neg;
        rowAddr_t addr;
        seedInit   = $urandom(32'h57569390);
        rstN       = 1'b0;
        wrEn       = 1'b0;
        wrAddr     = '0;
        wrData     = '0;
        rdEn       = 1'b0;
        rdAddr     = '0;
        macStart   = 1'b0;
        actPos     = '0;
        actNeg     = '0;
        strobeSeen = 1'b0;
        repeat (10) @(posedge CLK);
        #1;
        rstN = 1'b1;
        repeat (6) @(posedge CLK);
        #1;

        // The array has no reset, so every row gets known data first
        for (int i = 0; i < numRows; i++) begin
            writeRow(rowAddr_t'(i), colWord_t'($urandom));
        end
        for (int k = 0; k < numRwPairs; k++) begin
            addr = rowAddr_t'($urandom_range(numRows - 1, 0));
            writeRow(addr, colWord_t'($urandom));
            readRow(rowAddr_t'($urandom_range(numRows - 1, 0)));
            readRow(addr);
        end
        for (int k = 0; k < numReads; k++) begin
            readRow(rowAddr_t'($urandom_range(numRows - 1, 0)));
        end

        for (int k = 0; k < numMacs; k++) begin
            randomActivation(pos, neg, 1'b0);
            startMac(pos, neg);
            finishMacs();
        end

        // Two bursts with a new MAC every cycle
        for (int b = 0; b < 2; b++) begin
            for (int k = 0; k < 4; k++) begin
                randomActivation(pos, neg, b[0]);
                startMac(pos, neg);
            end
            finishMacs();
        end

        // Rows on both rails cancel out
        randomActivation(pos, neg, 1'b0);
        startMac(pos, pos);
        startMac('0, '0);
        randomActivation(pos, neg, 1'b1);
        startMac(pos, neg);
        finishMacs();

        // Known rows to push the slice to both ends of its range
        for (int i = 0; i < extremeRows; i++) begin
            writeRow(rowAddr_t'(i), (i < 32) ? 8'hFF : 8'h0F);
        end
        startMac(rowRange(0, 29), '0);
        startMac(rowRange(0, 31), '0);
        startMac('0, rowRange(0, 31));
        startMac('0, rowRange(0, 28));
        startMac(rowRange(0, 35), '0);
        startMac('0, rowRange(0, 3));
        finishMacs();

        repeat (4) @(posedge CLK);
        if (rdExpQ.size() != 0 || macExpQ.size() != 0) begin
            abortRun("Results were still pending at the end of the test");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

// File: hw/actDriver.sv
/*
 * Activation driver for the switch matrix
 * Registers a ternary vector into true and complement select rails
 */

`timescale 1ns/1ns

module actDriver import qraccPkg::*; (
    input  logic    CLK,
    input  logic    rstN,
    input  logic    macStart,
    input  rowVec_t actPos,
    input  rowVec_t actNeg,
    output rowVec_t vdrSel,
    output rowVec_t vdrSelB,
    output rowVec_t vssSel,
    output rowVec_t vssSelB,
    output logic    macIssued
);

    rowVec_t posMasked;
    rowVec_t negMasked;

    // A row asking for both rails is left floating
    assign posMasked = actPos & ~actNeg;
    assign negMasked = actNeg & ~actPos;

    // Select rails hold their value between MACs
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            vdrSel  <= '0;
            vdrSelB <= '1;
            vssSel  <= '0;
            vssSelB <= '1;
        end else if (macStart) begin
            vdrSel  <= posMasked;
            vdrSelB <= ~posMasked;
            vssSel  <= negMasked;
            vssSelB <= ~negMasked;
        end
    end

    // Tells the decoder that the column outputs settle this cycle
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            macIssued <= 1'b0;
        end else begin
            macIssued <= macStart;
        end
    end

    // Complement rails must track the true rails at all times
    assert property (@(posedge CLK) disable iff (!rstN)
        (vdrSelB == ~vdrSel) && (vssSelB == ~vssSel))
    else $error("Select complement rails out of step with true rails");

endmodule

// File: hw/adcDecode.sv
/*
 * Thermometer to signed decoder for all columns
 * Registers the MAC result with a one-cycle valid pulse
 */

`timescale 1ns/1ns

module adcDecode import qraccPkg::*; (
    input  logic       CLK,
    input  logic       rstN,
    input  logic       macIssued,
    input  thermCode_t adcOut,
    output adcVec_t    macResult,
    output logic       macValid
);

    adcVec_t decoded;

    // Count the tripped comparators and remove the zero offset
    always_comb begin : popCount
        int ones;
        for (int j = 0; j < numCols; j++) begin
            ones = 0;
            for (int i = 0; i < compCount; i++) begin
                ones = ones + int'(adcOut[j*compCount + i]);
            end
            decoded[j*numAdcBits +: numAdcBits] = adcVal_t'(ones - adcOffset);
        end
    end

    always_ff @(posedge CLK) begin
        if (macIssued) begin
            macResult <= decoded;
        end
    end

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            macValid <= 1'b0;
        end else begin
            macValid <= macIssued;
        end
    end

    // Each column must be a run of ones from bit 0, no bubbles
    for (genvar j = 0; j < numCols; j++) begin : gBubble
        logic [compCount-1:0] code;

        assign code = adcOut[j*compCount +: compCount];

        assert property (@(posedge CLK) disable iff (!rstN)
            macIssued |-> ((code & (code + 1'b1)) == '0))
        else $error("Thermometer bubble in column %0d: %h", j, code);
    end

endmodule

// File: hw/qraccColumn.sv
/*
 * Behavioural model of the compute-in-memory column block
 * Bit array with write and sense-amp read, per-column MAC and flash ADC
 */

`timescale 1ns/1ns

module qraccColumn import qraccPkg::*; (
    input  logic       CLK,

    // Switch matrix
    input  rowVec_t    VDR_SEL,
    input  rowVec_t    VDR_SELB,
    input  rowVec_t    VSS_SEL,
    input  rowVec_t    VSS_SELB,

    // SRAM
    input  rowVec_t    WL,
    input  logic       PCH,
    input  logic       WRITE,
    input  logic       SAEN,
    input  colWord_t   WR_DATA,
    output colWord_t   SA_OUT,

    // ADC
    output thermCode_t ADC_OUT
);

    colWord_t mem [numRows];

    rowVec_t drvPos;
    rowVec_t drvNeg;

    // Wide enough for the full signed range of numRows contributions
    logic signed [$clog2(numRows)+1:0] colSum [numCols];
    adcVal_t colVal [numCols];

    // Array write, no reset on the cells
    always_ff @(posedge CLK) begin
        if (PCH && WRITE) begin
            for (int i = 0; i < numRows; i++) begin
                if (WL[i]) begin
                    mem[i] <= WR_DATA;
                end
            end
        end
    end

    // Sense amps are not latched in the array
    always_comb begin : senseAmp
        SA_OUT = '0;
        if (PCH && SAEN) begin
            for (int i = 0; i < numRows; i++) begin
                if (WL[i]) begin
                    SA_OUT = SA_OUT | mem[i];
                end
            end
        end
    end

    // A switch conducts only when its true and complement controls agree
    assign drvPos = VDR_SEL & ~VDR_SELB;
    assign drvNeg = VSS_SEL & ~VSS_SELB;

    // Charge sharing on each bit line, counted as a signed sum
    always_comb begin : macSum
        for (int j = 0; j < numCols; j++) begin
            colSum[j] = '0;
            for (int i = 0; i < numRows; i++) begin
                if (mem[i][j]) begin
                    if (drvPos[i]) begin
                        colSum[j] = colSum[j] + 1;
                    end
                    if (drvNeg[i]) begin
                        colSum[j] = colSum[j] - 1;
                    end
                end
            end
            // ADC full scale sits on bits 5:2 of the sum
            colVal[j] = colSum[j][5 -: numAdcBits];
        end
    end

    // Flash ADC, comparator i trips once the shifted level exceeds i
    always_comb begin : flashAdc
        for (int j = 0; j < numCols; j++) begin
            for (int i = 0; i < compCount; i++) begin
                ADC_OUT[j*compCount + i] = (int'(colVal[j]) + adcOffset > i);
            end
        end
    end

endmodule

// File: hw/qraccPkg.sv
/*
 * Shared sizes, vector types and the weight-port state encoding
 * for the ternary compute-in-memory column tile
 */

package qraccPkg;

    // Array geometry
    localparam int numRows = 128;
    localparam int numCols = 8;

    // Flash ADC with one comparator per thermometer step
    localparam int numAdcBits = 4;
    localparam int compCount = (2 ** numAdcBits) - 1;

    // Thermometer count of a zero result
    localparam int adcOffset = 8;

    // One bit per row, used for select lines and word lines
    typedef logic [numRows-1:0] rowVec_t;

    typedef logic [$clog2(numRows)-1:0] rowAddr_t;

    // A stored row, one bit per column
    typedef logic [numCols-1:0] colWord_t;

    // Comparator outputs, column j starts at bit j*compCount
    typedef logic [compCount*numCols-1:0] thermCode_t;

    // Signed column result and all columns packed together
    typedef logic signed [numAdcBits-1:0] adcVal_t;
    typedef logic [numAdcBits*numCols-1:0] adcVec_t;

    // Weight port sequencing
    typedef enum logic [1:0] {
        WP_IDLE,
        WP_WRITE,
        WP_READ
    } wpState_t;

endpackage

// File: hw/qraccTile.sv
/*
 * Column tile top level
 * Activation driver, weight port, column model and ADC decoder
 */

`timescale 1ns/1ns

module qraccTile import qraccPkg::*; (
    input  logic     CLK,
    input  logic     rstN,

    // Weight write and readback
    input  logic     wrEn,
    input  rowAddr_t wrAddr,
    input  colWord_t wrData,
    input  logic     rdEn,
    input  rowAddr_t rdAddr,
    output colWord_t rdData,
    output logic     rdValid,
    output logic     busy,

    // MAC request and result
    input  logic     macStart,
    input  rowVec_t  actPos,
    input  rowVec_t  actNeg,
    output adcVec_t  macResult,
    output logic     macValid
);

    rowVec_t    vdrSel;
    rowVec_t    vdrSelB;
    rowVec_t    vssSel;
    rowVec_t    vssSelB;
    logic       macIssued;

    rowVec_t    wl;
    logic       pch;
    logic       write;
    logic       saEn;
    colWord_t   wrDataOut;
    colWord_t   saOut;

    thermCode_t adcOut;

    actDriver uActDriver (
        .CLK       (CLK),
        .rstN      (rstN),
        .macStart  (macStart),
        .actPos    (actPos),
        .actNeg    (actNeg),
        .vdrSel    (vdrSel),
        .vdrSelB   (vdrSelB),
        .vssSel    (vssSel),
        .vssSelB   (vssSelB),
        .macIssued (macIssued)
    );

    weightPort uWeightPort (
        .CLK       (CLK),
        .rstN      (rstN),
        .wrEn      (wrEn),
        .rdEn      (rdEn),
        .wrAddr    (wrAddr),
        .rdAddr    (rdAddr),
        .wrData    (wrData),
        .saOut     (saOut),
        .wl        (wl),
        .pch       (pch),
        .write     (write),
        .saEn      (saEn),
        .wrDataOut (wrDataOut),
        .rdData    (rdData),
        .rdValid   (rdValid),
        .busy      (busy)
    );

    qraccColumn uColumn (
        .CLK      (CLK),
        .VDR_SEL  (vdrSel),
        .VDR_SELB (vdrSelB),
        .VSS_SEL  (vssSel),
        .VSS_SELB (vssSelB),
        .WL       (wl),
        .PCH      (pch),
        .WRITE    (write),
        .SAEN     (saEn),
        .WR_DATA  (wrDataOut),
        .SA_OUT   (saOut),
        .ADC_OUT  (adcOut)
    );

    adcDecode uAdcDecode (
        .CLK       (CLK),
        .rstN      (rstN),
        .macIssued (macIssued),
        .adcOut    (adcOut),
        .macResult (macResult),
        .macValid  (macValid)
    );

endmodule

// File: hw/weightPort.sv
/*
 * Weight port for the SRAM array
 * Write and read sequencing onto word line, precharge, write and sense controls
 */

`timescale 1ns/1ns

module weightPort import qraccPkg::*; (
    input  logic     CLK,
    input  logic     rstN,
    input  logic     wrEn,
    input  logic     rdEn,
    input  rowAddr_t wrAddr,
    input  rowAddr_t rdAddr,
    input  colWord_t wrData,
    input  colWord_t saOut,
    output rowVec_t  wl,
    output logic     pch,
    output logic     write,
    output logic     saEn,
    output colWord_t wrDataOut,
    output colWord_t rdData,
    output logic     rdValid,
    output logic     busy
);

    wpState_t state;
    rowVec_t  rowSel;

    // Writes take priority over reads in the same cycle
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            state <= WP_IDLE;
        end else begin
            case (state)
                WP_IDLE: begin
                    if (wrEn) begin
                        state <= WP_WRITE;
                    end else if (rdEn) begin
                        state <= WP_READ;
                    end
                end
                default: state <= WP_IDLE;
            endcase
        end
    end

    // One-hot row decode and write data are latched on request
    always_ff @(posedge CLK) begin
        if (state == WP_IDLE) begin
            if (wrEn) begin
                rowSel    <= rowVec_t'(1) << wrAddr;
                wrDataOut <= wrData;
            end else if (rdEn) begin
                rowSel <= rowVec_t'(1) << rdAddr;
            end
        end
    end

    // Array controls are live for the single access cycle
    assign busy  = (state != WP_IDLE);
    assign pch   = busy;
    assign write = (state == WP_WRITE);
    assign saEn  = (state == WP_READ);
    assign wl    = busy ? rowSel : '0;

    // Sense amp output is sampled at the end of the read cycle
    always_ff @(posedge CLK) begin
        if (state == WP_READ) begin
            rdData <= saOut;
        end
    end

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            rdValid <= 1'b0;
        end else begin
            rdValid <= (state == WP_READ);
        end
    end

    // Exactly one word line during any precharged access
    assert property (@(posedge CLK) disable iff (!rstN)
        pch |-> $onehot(wl))
    else $error("Word line not one-hot during access");

    // Requests while busy would be dropped
    assert property (@(posedge CLK) disable iff (!rstN)
        busy |-> !(wrEn || rdEn))
    else $error("Weight port request while busy");

endmodule

// File: src.f
hw/qraccPkg.sv
hw/actDriver.sv
hw/weightPort.sv
hw/qraccColumn.sv
hw/adcDecode.sv
hw/qraccTile.sv
bench/qraccTileTb.sv
